// File: tb.f
source/i2c_cmd_pkg.sv
source/wbs_reg_pkg.sv
source/stream_fifo.sv
source/wbs_reg_ctrl.sv
source/i2c_wbs_top.sv
verification/tb_i2c_wbs.sv

// File: Bender.yml
package:
  name: i2c_wbs

sources:
  - files:
      - source/i2c_cmd_pkg.sv
      - source/wbs_reg_pkg.sv
      - source/stream_fifo.sv
      - source/wbs_reg_ctrl.sv
      - source/i2c_wbs_top.sv
  - target: test
    files:
      - verification/tb_i2c_wbs.sv

// File: verification/tb_i2c_wbs.sv
`timescale 1ns/100ps
/* Testbench for the I2C host register block
   Random bus traffic, engine stream model, reference queues and flags */
module tb_i2c_wbs
    import i2c_cmd_pkg::*, wbs_reg_pkg::*;
;

    localparam int unsigned FIFO_DEPTH = 4;
    localparam int N_RAND = 300;
    localparam int N_DIRECTED = 30;
    localparam int WATCHDOG_CYCLES = (N_RAND + N_DIRECTED) * 4 + 1000;

    logic           clk;
    logic           rst;
    logic [2:0]     wbs_adr_i;
    i2c_byte_t      wbs_dat_i;
    i2c_byte_t      wbs_dat_o;
    logic           wbs_we_i;
    logic           wbs_stb_i;
    logic           wbs_ack_o;
    logic           wbs_cyc_i;
    i2c_cmd_t       cmd_o;
    logic           cmd_valid_o;
    logic           cmd_ready_i;
    wr_beat_t       wr_o;
    logic           wr_valid_o;
    logic           wr_ready_i;
    rd_beat_t       rd_i;
    logic           rd_valid_i;
    logic           rd_ready_o;
    engine_status_t status_i;
    prescale_t      prescale_o;

    int seed = 54;
    // Random stream of the engine model
    int eng_seed = 55;
    int errors = 0;
    // Engine mode 0 random, 1 stalled, 2 draining
    int engine_mode = 1;
    logic rd_stalled;

    // Reference model state
    i2c_cmd_t  exp_cmd_q[$];
    i2c_byte_t exp_wr_q[$];
    i2c_byte_t exp_rd_q[$];
    i2c_addr_t m_addr = '0;
    logic      m_start = 1'b0;
    logic      m_read = 1'b0;
    logic      m_write = 1'b0;
    logic      m_stop = 1'b0;
    prescale_t m_prescale = 16'd1;
    logic      m_miss = 1'b0;
    logic      m_cmd_ovf = 1'b0;
    logic      m_wr_ovf = 1'b0;
    // Expected acknowledge level
    logic      m_ack = 1'b0;
    // Strobes raised by the last access and due at the next edge
    logic      pend_cmd = 1'b0;
    i2c_cmd_t  pend_cmd_val;
    logic      pend_wr = 1'b0;
    i2c_byte_t pend_wr_val;
    logic      pend_pop = 1'b0;
    i2c_byte_t exp_rd;
    logic      exp_rd_known = 1'b0;

    i2c_wbs_top #(
        .DEFAULT_PRESCALE(16'd1),
        .FIXED_PRESCALE  (1'b0),
        .CMD_FIFO_DEPTH  (FIFO_DEPTH),
        .WRITE_FIFO_DEPTH(FIFO_DEPTH),
        .READ_FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk(clk), .rst(rst),
        .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i), .wbs_dat_o(wbs_dat_o),
        .wbs_we_i(wbs_we_i), .wbs_stb_i(wbs_stb_i), .wbs_ack_o(wbs_ack_o),
        .wbs_cyc_i(wbs_cyc_i),
        .cmd_o(cmd_o), .cmd_valid_o(cmd_valid_o), .cmd_ready_i(cmd_ready_i),
        .wr_o(wr_o), .wr_valid_o(wr_valid_o), .wr_ready_i(wr_ready_i),
        .rd_i(rd_i), .rd_valid_i(rd_valid_i), .rd_ready_o(rd_ready_o),
        .status_i(status_i), .prescale_o(prescale_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One register access that returns once ack is seen
    task automatic bus_access(input logic [2:0] adr, input logic we, input i2c_byte_t dat,
                              output i2c_byte_t rdata);
        int waited;
        waited = 0;
        rdata = '0;
        wbs_adr_i = adr;
        wbs_we_i = we;
        wbs_dat_i = dat;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wbs_ack_o && waited < 8);
        if (!wbs_ack_o) begin
            errors++;
            $display("No acknowledge within 8 cycles for access to register %0d", adr);
        end else begin
            rdata = wbs_dat_o;
            if (!we && exp_rd_known) begin
                check_value("wbs_dat_o", exp_rd, wbs_dat_o);
            end
        end
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
    endtask

    // Register byte expected from model state
    function automatic i2c_byte_t expected_read(input logic [2:0] adr);
        case (adr)
            REG_STATUS: return {4'b0, m_miss, status_i.bus_active, status_i.bus_control,
                                status_i.busy};
            REG_FIFO_STATUS: return {exp_rd_q.size() == FIFO_DEPTH, exp_rd_q.size() == 0,
                                     m_wr_ovf, exp_wr_q.size() == FIFO_DEPTH,
                                     exp_wr_q.size() == 0, m_cmd_ovf,
                                     exp_cmd_q.size() == FIFO_DEPTH, exp_cmd_q.size() == 0};
            REG_CMD_ADDR:    return {1'b0, m_addr};
            // Block write bit always reads 0
            REG_COMMAND:     return {3'b0, m_stop, 1'b0, m_write, m_read, m_start};
            REG_DATA:        return (exp_rd_q.size() != 0) ? exp_rd_q[0] : 8'h00;
            REG_PRESCALE_LO: return m_prescale[7:0];
            REG_PRESCALE_HI: return m_prescale[15:8];
            default:         return 8'h00;
        endcase
    endfunction

    // Reference model stepping once per clock edge on pre-edge values
    always @(negedge clk) begin
        logic      first_cyc;
        logic      rd_nonempty;
        logic      clr_miss;
        logic      clr_cmd;
        logic      clr_wr;
        logic      cmd_was_full;
        logic      wr_was_full;
        logic      rd_was_full;
        i2c_byte_t d;
        if (!rst) begin
            // Stream outputs against model occupancy
            check_value("wbs_ack_o", m_ack, wbs_ack_o);
            check_value("cmd_valid_o", exp_cmd_q.size() != 0, cmd_valid_o);
            if (exp_cmd_q.size() != 0) begin
                check_value("cmd_o", exp_cmd_q[0], cmd_o);
            end
            check_value("wr_valid_o", exp_wr_q.size() != 0, wr_valid_o);
            if (exp_wr_q.size() != 0) begin
                check_value("wr_o", {exp_wr_q[0], 1'b0}, wr_o);
            end
            check_value("rd_ready_o", exp_rd_q.size() < FIFO_DEPTH, rd_ready_o);
            check_value("prescale_o", m_prescale, prescale_o);

            first_cyc = wbs_cyc_i && wbs_stb_i && !m_ack;
            rd_nonempty = exp_rd_q.size() != 0;
            d = wbs_dat_i;
            if (first_cyc && !wbs_we_i) begin
                exp_rd = expected_read(wbs_adr_i);
                exp_rd_known = !(wbs_adr_i == REG_DATA && !rd_nonempty);
            end
            clr_miss = first_cyc && wbs_we_i && wbs_adr_i == REG_STATUS && d[3];
            clr_cmd = first_cyc && wbs_we_i && wbs_adr_i == REG_FIFO_STATUS && d[2];
            clr_wr = first_cyc && wbs_we_i && wbs_adr_i == REG_FIFO_STATUS && d[5];

            // Full is judged before any pop in the same edge
            cmd_was_full = exp_cmd_q.size() == FIFO_DEPTH;
            wr_was_full = exp_wr_q.size() == FIFO_DEPTH;
            rd_was_full = exp_rd_q.size() == FIFO_DEPTH;
            if (cmd_ready_i && exp_cmd_q.size() != 0) begin
                void'(exp_cmd_q.pop_front());
            end
            if (wr_ready_i && exp_wr_q.size() != 0) begin
                void'(exp_wr_q.pop_front());
            end
            m_cmd_ovf = (pend_cmd && cmd_was_full) || (m_cmd_ovf && !clr_cmd);
            m_wr_ovf = (pend_wr && wr_was_full) || (m_wr_ovf && !clr_wr);
            if (pend_cmd && !cmd_was_full) begin
                exp_cmd_q.push_back(pend_cmd_val);
            end
            if (pend_wr && !wr_was_full) begin
                exp_wr_q.push_back(pend_wr_val);
            end
            if (pend_pop) begin
                void'(exp_rd_q.pop_front());
            end
            if (rd_valid_i && !rd_was_full) begin
                exp_rd_q.push_back(rd_i.data);
            end
            // Pulse wins over a clear
            m_miss = status_i.missed_ack || (m_miss && !clr_miss);
            // Ack follows the first cycle and drops on the next
            m_ack = first_cyc;

            pend_cmd = 1'b0;
            pend_wr = 1'b0;
            pend_pop = first_cyc && !wbs_we_i && wbs_adr_i == REG_DATA && rd_nonempty;
            if (first_cyc && wbs_we_i) begin
                case (wbs_adr_i)
                    REG_CMD_ADDR: m_addr = d[6:0];
                    REG_COMMAND: begin
                        {m_stop, m_write, m_read, m_start} = {d[4], d[2], d[1], d[0]};
                        pend_cmd = d[4] | d[2] | d[1] | d[0];
                        pend_cmd_val = '{addr: m_addr, start: d[0], read: d[1],
                                         write: d[2], stop: d[4]};
                    end
                    REG_DATA: begin
                        pend_wr = 1'b1;
                        pend_wr_val = d;
                    end
                    REG_PRESCALE_LO: m_prescale[7:0] = d;
                    REG_PRESCALE_HI: m_prescale[15:8] = d;
                    default: ;
                endcase
            end
        end
    end

    // Engine model holding read beats until accepted
    always begin
        @(negedge clk);
        rd_stalled = rd_valid_i && !rd_ready_o;
        @(posedge clk);
        #1;
        if (!rst) begin
            status_i.busy = $random(eng_seed);
            status_i.bus_control = $random(eng_seed);
            status_i.bus_active = $random(eng_seed);
            status_i.missed_ack = ($random(eng_seed) & 15) == 0;
            cmd_ready_i = (engine_mode == 2) || (engine_mode == 0 && ($random(eng_seed) & 3) != 0);
            wr_ready_i = (engine_mode == 2) || (engine_mode == 0 && ($random(eng_seed) & 3) != 0);
            if (!rd_stalled) begin
                rd_valid_i = engine_mode == 0 && ($random(eng_seed) & 3) == 0;
                rd_i = rd_beat_t'($random(eng_seed));
            end
        end
    end

    initial begin
        i2c_byte_t  rdata;
        logic [2:0] adr;
        logic       we;
        rst = 1'b1;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        wbs_we_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        cmd_ready_i = 1'b0;
        wr_ready_i = 1'b0;
        rd_i = '0;
        rd_valid_i = 1'b0;
        status_i = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(2);

        // Reset values
        check_value("prescale_o", 16'd1, prescale_o);
        bus_access(REG_PRESCALE_LO, 1'b0, 8'h00, rdata);
        check_value("prescale lo byte", 16'd1, rdata);
        bus_access(REG_RESERVED, 1'b0, 8'h00, rdata);
        check_value("reserved byte", 16'd0, rdata);

        // Write queue overflow with the engine stalled
        repeat (FIFO_DEPTH + 1) bus_access(REG_DATA, 1'b1, 8'($random(seed)), rdata);
        bus_access(REG_FIFO_STATUS, 1'b0, 8'h00, rdata);
        check_value("wr_ovf and wr_full", 16'h3, rdata[5:4]);
        bus_access(REG_FIFO_STATUS, 1'b1, 8'h20, rdata);
        bus_access(REG_FIFO_STATUS, 1'b0, 8'h00, rdata);
        check_value("wr_ovf after clear", 16'h0, rdata[5]);

        // Command queue overflow
        bus_access(REG_CMD_ADDR, 1'b1, 8'($random(seed)), rdata);
        repeat (FIFO_DEPTH + 1) bus_access(REG_COMMAND, 1'b1, 8'($random(seed)) | 8'h01, rdata);
        bus_access(REG_FIFO_STATUS, 1'b0, 8'h00, rdata);
        check_value("cmd_ovf and cmd_full", 16'h3, rdata[2:1]);
        bus_access(REG_FIFO_STATUS, 1'b1, 8'h04, rdata);
        bus_access(REG_FIFO_STATUS, 1'b0, 8'h00, rdata);
        check_value("cmd_ovf after clear", 16'h0, rdata[2]);

        // Random traffic against a random engine
        engine_mode = 0;
        for (int i = 0; i < N_RAND; i++) begin
            adr = 3'($random(seed));
            we = 1'($random(seed));
            bus_access(adr, we, 8'($random(seed)), rdata);
            idle_cycles($random(seed) & 1);
        end

        // Drain every queue and expect all empty
        engine_mode = 2;
        idle_cycles(16);
        repeat (FIFO_DEPTH + 1) bus_access(REG_DATA, 1'b0, 8'h00, rdata);
        idle_cycles(2);
        bus_access(REG_FIFO_STATUS, 1'b0, 8'h00, rdata);
        check_value("settled queue flags", 16'h49, rdata & 8'hDB);

        $display("Finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: source/i2c_wbs_top.sv
`timescale 1ns/100ps
/* I2C master host register block with command, write and read queues */
module i2c_wbs_top
    import i2c_cmd_pkg::*, wbs_reg_pkg::*;
#(
    parameter prescale_t   DEFAULT_PRESCALE = 16'd1,
    parameter bit          FIXED_PRESCALE   = 1'b0,
    parameter int unsigned CMD_FIFO_DEPTH   = 32,
    parameter int unsigned WRITE_FIFO_DEPTH = 32,
    parameter int unsigned READ_FIFO_DEPTH  = 32
) (
    input  logic           clk,
    input  logic           rst,
    // Host register bus
    input  logic [2:0]     wbs_adr_i,
    input  i2c_byte_t      wbs_dat_i,
    output i2c_byte_t      wbs_dat_o,
    input  logic           wbs_we_i,
    input  logic           wbs_stb_i,
    output logic           wbs_ack_o,
    input  logic           wbs_cyc_i,
    // Bit engine streams
    output i2c_cmd_t       cmd_o,
    output logic           cmd_valid_o,
    input  logic           cmd_ready_i,
    output wr_beat_t       wr_o,
    output logic           wr_valid_o,
    input  logic           wr_ready_i,
    input  rd_beat_t       rd_i,
    input  logic           rd_valid_i,
    output logic           rd_ready_o,
    input  engine_status_t status_i,
    output prescale_t      prescale_o
);

    // Controller to queue inputs
    i2c_cmd_t cmd_in;
    logic     cmd_push;
    logic     cmd_in_ready;
    wr_beat_t wr_in;
    logic     wr_push;
    logic     wr_in_ready;
    // Read queue head back to the controller
    rd_beat_t rd_head;
    logic     rd_head_valid;
    logic     rd_pop;

    wbs_reg_ctrl #(
        .DEFAULT_PRESCALE(DEFAULT_PRESCALE),
        .FIXED_PRESCALE  (FIXED_PRESCALE)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .adr_i      (reg_addr_e'(wbs_adr_i)),
        .dat_i      (wbs_dat_i),
        .we_i       (wbs_we_i),
        .stb_i      (wbs_stb_i),
        .cyc_i      (wbs_cyc_i),
        .dat_o      (wbs_dat_o),
        .ack_o      (wbs_ack_o),
        .cmd_o      (cmd_in),
        .cmd_push_o (cmd_push),
        .cmd_ready_i(cmd_in_ready),
        .cmd_valid_i(cmd_valid_o),
        .wr_o       (wr_in),
        .wr_push_o  (wr_push),
        .wr_ready_i (wr_in_ready),
        .wr_valid_i (wr_valid_o),
        .rd_head_i  (rd_head),
        .rd_valid_i (rd_head_valid),
        .rd_full_i  (~rd_ready_o),
        .rd_pop_o   (rd_pop),
        .status_i   (status_i),
        .prescale_o (prescale_o)
    );

    stream_fifo #(.WIDTH($bits(i2c_cmd_t)), .DEPTH(CMD_FIFO_DEPTH)) u_cmd_fifo (
        .clk        (clk),
        .rst        (rst),
        .in_data_i  (cmd_in),
        .in_valid_i (cmd_push),
        .in_ready_o (cmd_in_ready),
        .out_data_o (cmd_o),
        .out_valid_o(cmd_valid_o),
        .out_ready_i(cmd_ready_i)
    );

    stream_fifo #(.WIDTH($bits(wr_beat_t)), .DEPTH(WRITE_FIFO_DEPTH)) u_wr_fifo (
        .clk        (clk),
        .rst        (rst),
        .in_data_i  (wr_in),
        .in_valid_i (wr_push),
        .in_ready_o (wr_in_ready),
        .out_data_o (wr_o),
        .out_valid_o(wr_valid_o),
        .out_ready_i(wr_ready_i)
    );

    // Engine fills, host register reads drain
    stream_fifo #(.WIDTH($bits(rd_beat_t)), .DEPTH(READ_FIFO_DEPTH)) u_rd_fifo (
        .clk        (clk),
        .rst        (rst),
        .in_data_i  (rd_i),
        .in_valid_i (rd_valid_i),
        .in_ready_o (rd_ready_o),
        .out_data_o (rd_head),
        .out_valid_o(rd_head_valid),
        .out_ready_i(rd_pop)
    );

endmodule

// File: source/wbs_reg_ctrl.sv
`timescale 1ns/100ps
/* Host byte-register decoder with toggling acknowledge
   Sticky flags, prescale register and queue push/pop strobes */
module wbs_reg_ctrl
    import i2c_cmd_pkg::*, wbs_reg_pkg::*;
#(
    parameter prescale_t DEFAULT_PRESCALE = 16'd1,
    parameter bit        FIXED_PRESCALE   = 1'b0
) (
    input  logic           clk,
    input  logic           rst,
    // Host register bus
    input  reg_addr_e      adr_i,
    input  i2c_byte_t      dat_i,
    input  logic           we_i,
    input  logic           stb_i,
    input  logic           cyc_i,
    output i2c_byte_t      dat_o,
    output logic           ack_o,
    // Command queue
    output i2c_cmd_t       cmd_o,
    output logic           cmd_push_o,
    input  logic           cmd_ready_i,
    input  logic           cmd_valid_i,
    // Write-data queue
    output wr_beat_t       wr_o,
    output logic           wr_push_o,
    input  logic           wr_ready_i,
    input  logic           wr_valid_i,
    // Read-data queue
    input  rd_beat_t       rd_head_i,
    input  logic           rd_valid_i,
    input  logic           rd_full_i,
    output logic           rd_pop_o,
    // Engine side
    input  engine_status_t status_i,
    output prescale_t      prescale_o
);

    logic      access;
    logic      first;
    logic      wr_en;
    logic      rd_en;
    reg_byte_u wr_byte;
    reg_byte_u rd_byte;
    logic      cmd_action;
    logic      clr_miss_ack;
    logic      clr_cmd_ovf;
    logic      clr_wr_ovf;

    logic      ack_q;
    i2c_byte_t dat_q;
    i2c_cmd_t  cmd_q;
    i2c_byte_t data_q;
    logic      cmd_push_q;
    logic      wr_push_q;
    logic      rd_pop_q;
    prescale_t prescale_q;
    logic      miss_ack_q;
    logic      cmd_ovf_q;
    logic      wr_ovf_q;

    // Side effects only in the first cycle of an access, ack still low
    assign access = cyc_i & stb_i;
    assign first  = access & ~ack_q;
    assign wr_en  = first & we_i;
    assign rd_en  = first & ~we_i;

    // Written byte, decoded by address below
    assign wr_byte    = reg_byte_u'(dat_i);
    assign cmd_action = wr_byte.cmd.start | wr_byte.cmd.read |
                        wr_byte.cmd.write | wr_byte.cmd.stop;

    // Write-1-to-clear requests
    assign clr_miss_ack = wr_en && adr_i == REG_STATUS && wr_byte.status.miss_ack;
    assign clr_cmd_ovf  = wr_en && adr_i == REG_FIFO_STATUS && wr_byte.fifo.cmd_ovf;
    assign clr_wr_ovf   = wr_en && adr_i == REG_FIFO_STATUS && wr_byte.fifo.wr_ovf;

    // Read byte assembled per address
    always_comb begin
        rd_byte.raw = '0;
        case (adr_i)
            REG_STATUS: begin
                rd_byte.status.busy     = status_i.busy;
                rd_byte.status.bus_cont = status_i.bus_control;
                rd_byte.status.bus_act  = status_i.bus_active;
                rd_byte.status.miss_ack = miss_ack_q;
            end
            REG_FIFO_STATUS: begin
                rd_byte.fifo.cmd_empty = ~cmd_valid_i;
                rd_byte.fifo.cmd_full  = ~cmd_ready_i;
                rd_byte.fifo.cmd_ovf   = cmd_ovf_q;
                rd_byte.fifo.wr_empty  = ~wr_valid_i;
                rd_byte.fifo.wr_full   = ~wr_ready_i;
                rd_byte.fifo.wr_ovf    = wr_ovf_q;
                rd_byte.fifo.rd_empty  = ~rd_valid_i;
                rd_byte.fifo.rd_full   = rd_full_i;
            end
            REG_CMD_ADDR: rd_byte.raw = {1'b0, cmd_q.addr};
            REG_COMMAND: begin
                rd_byte.cmd.start = cmd_q.start;
                rd_byte.cmd.read  = cmd_q.read;
                rd_byte.cmd.write = cmd_q.write;
                rd_byte.cmd.stop  = cmd_q.stop;
            end
            // Head of read queue, undefined when empty
            REG_DATA:        rd_byte.raw = rd_head_i.data;
            REG_RESERVED:    rd_byte.raw = '0;
            REG_PRESCALE_LO: rd_byte.raw = prescale_q[7:0];
            REG_PRESCALE_HI: rd_byte.raw = prescale_q[15:8];
            default:         rd_byte.raw = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q      <= 1'b0;
            dat_q      <= '0;
            cmd_q      <= '0;
            cmd_push_q <= 1'b0;
            wr_push_q  <= 1'b0;
            rd_pop_q   <= 1'b0;
            prescale_q <= DEFAULT_PRESCALE;
            miss_ack_q <= 1'b0;
            cmd_ovf_q  <= 1'b0;
            wr_ovf_q   <= 1'b0;
        end else begin
            // Ack toggles while the request is held
            ack_q <= access & ~ack_q;
            dat_q <= (access && !we_i) ? rd_byte.raw : '0;

            // One-cycle strobes toward the queues
            cmd_push_q <= wr_en && adr_i == REG_COMMAND && cmd_action;
            wr_push_q  <= wr_en && adr_i == REG_DATA;
            // Pop lands at the end of the ack cycle
            rd_pop_q   <= rd_en && adr_i == REG_DATA && rd_valid_i;

            if (wr_en && adr_i == REG_CMD_ADDR) begin
                cmd_q.addr <= wr_byte.raw[6:0];
            end
            if (wr_en && adr_i == REG_COMMAND) begin
                cmd_q.start <= wr_byte.cmd.start;
                cmd_q.read  <= wr_byte.cmd.read;
                cmd_q.write <= wr_byte.cmd.write;
                cmd_q.stop  <= wr_byte.cmd.stop;
            end

            if (!FIXED_PRESCALE && wr_en) begin
                if (adr_i == REG_PRESCALE_LO) begin
                    prescale_q[7:0] <= wr_byte.raw;
                end
                if (adr_i == REG_PRESCALE_HI) begin
                    prescale_q[15:8] <= wr_byte.raw;
                end
            end

            // New event beats a clear in the same cycle
            miss_ack_q <= status_i.missed_ack | (miss_ack_q & ~clr_miss_ack);
            // Push into a full queue drops the byte
            cmd_ovf_q  <= (cmd_push_q & ~cmd_ready_i) | (cmd_ovf_q & ~clr_cmd_ovf);
            wr_ovf_q   <= (wr_push_q & ~wr_ready_i) | (wr_ovf_q & ~clr_wr_ovf);
        end
    end

    // Outgoing data byte
    always_ff @(posedge clk) begin
        if (wr_en && adr_i == REG_DATA) begin
            data_q <= dat_i;
        end
    end

    assign ack_o      = ack_q;
    assign dat_o      = dat_q;
    assign cmd_o      = cmd_q;
    assign cmd_push_o = cmd_push_q;
    assign wr_o       = '{data: data_q, last: 1'b0};
    assign wr_push_o  = wr_push_q;
    assign rd_pop_o   = rd_pop_q;
    assign prescale_o = prescale_q;

    a_ack_toggle: assert property (@(posedge clk) disable iff (rst)
        ack_q |=> !ack_q);

    a_cmd_push_single: assert property (@(posedge clk) disable iff (rst)
        cmd_push_q |=> !cmd_push_q);

endmodule

// File: source/stream_fifo.sv
`timescale 1ns/100ps
/* Valid/ready FIFO with first-word fall-through output
   Circular buffer storage and a registered head word */
module stream_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] in_data_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    output logic [WIDTH-1:0] out_data_o,
    output logic             out_valid_o,
    input  logic             out_ready_i
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_next;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic [WIDTH-1:0] head_q;
    logic             head_valid_q;
    logic             push;
    logic             pop;

    // Wrapping pointer step, DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready_o  = (count != CNT_W'(DEPTH));
    assign push        = in_valid_i & in_ready_o;
    assign pop         = head_valid_q & out_ready_i;
    assign rd_ptr_next = pop ? ptr_inc(rd_ptr) : rd_ptr;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // Pointers, occupancy and head valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            head_valid_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr       <= rd_ptr_next;
            count        <= count_next;
            head_valid_q <= (count_next != '0);
        end
    end

    // Storage and head copy
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
        // Buffer empty after this pop, so the new word goes straight to the head
        if (push && count == CNT_W'(pop)) begin
            head_q <= in_data_i;
        end else begin
            head_q <= mem[rd_ptr_next];
        end
    end

    assign out_data_o  = head_q;
    assign out_valid_o = head_valid_q;

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH));

    a_empty_no_valid: assert property (@(posedge clk) disable iff (rst)
        (count == '0) |-> !out_valid_o);

endmodule

// File: source/wbs_reg_pkg.sv
/* Host register map and the byte layouts of the status and command registers */
package wbs_reg_pkg;

    // Byte register addresses on the host bus
    typedef enum logic [2:0] {
        REG_STATUS      = 3'd0,
        REG_FIFO_STATUS = 3'd1,
        REG_CMD_ADDR    = 3'd2,
        REG_COMMAND     = 3'd3,
        REG_DATA        = 3'd4,
        REG_RESERVED    = 3'd5,
        REG_PRESCALE_LO = 3'd6,
        REG_PRESCALE_HI = 3'd7
    } reg_addr_e;

    // Engine status byte, miss_ack is sticky and write-1-to-clear
    typedef struct packed {
        logic [3:0] zero;
        logic       miss_ack;
        logic       bus_act;
        logic       bus_cont;
        logic       busy;
    } status_bits_t;

    // Queue levels and overflow flags
    // Overflow bits are sticky and write-1-to-clear
    typedef struct packed {
        logic rd_full;
        logic rd_empty;
        logic wr_ovf;
        logic wr_full;
        logic wr_empty;
        logic cmd_ovf;
        logic cmd_full;
        logic cmd_empty;
    } fifo_status_bits_t;

    // Command byte, any of start/read/write/stop pushes a command
    typedef struct packed {
        logic [2:0] zero;
        logic       stop;
        // Block write, not supported
        logic       write_multiple;
        logic       write;
        logic       read;
        logic       start;
    } command_bits_t;

    // One register byte seen through the layout of its address
    typedef union packed {
        logic [7:0]        raw;
        status_bits_t      status;
        fifo_status_bits_t fifo;
        command_bits_t     cmd;
    } reg_byte_u;

endpackage

// File: source/i2c_cmd_pkg.sv
/* Engine-side types: commands, data beats, engine status and prescale */
package i2c_cmd_pkg;

    // 7-bit device address on the I2C bus
    typedef logic [6:0] i2c_addr_t;

    // One data byte in either direction
    typedef logic [7:0] i2c_byte_t;

    // Engine clock divider, quarter of the SCL period in clk cycles
    typedef logic [15:0] prescale_t;

    // Command word handed to the bit engine
    // Start goes first, then read or write, then stop
    typedef struct packed {
        i2c_addr_t addr;
        logic      start;
        logic      read;
        logic      write;
        logic      stop;
    } i2c_cmd_t;

    // Byte for the engine to transmit
    // Last marks the end of a block write, held at 0 by this block
    typedef struct packed {
        i2c_byte_t data;
        logic      last;
    } wr_beat_t;

    // Byte received by the engine
    // Last comes with a read that carried stop
    typedef struct packed {
        i2c_byte_t data;
        logic      last;
    } rd_beat_t;

    // Live status from the engine
    typedef struct packed {
        logic busy;
        logic bus_control;
        logic bus_active;
        // One-cycle strobe per missed slave acknowledge
        logic missed_ack;
    } engine_status_t;

endpackage
